// ==== Makefile ====
TOP := tb_ex_stage

.PHONY: all run lint clean

all: run

obj_dir/sim: tb.f logic/*.sv logic/*.svh tests/*.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim

run: obj_dir/sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    input  ex_pkg::alu_op_t op,
    output ex_pkg::word_t   res
);
    import ex_pkg::*;

    logic [4:0] shamt; // RV32I shifts use 5 bits
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            alu_add:    res = a + b;
            alu_sub:    res = a - b;
            alu_sll:    res = a << shamt;
            alu_slt:    res = word_t'(lt_s);             // Zero-extended flag
            alu_sltu:   res = word_t'(lt_u);
            alu_xor:    res = a ^ b;
            alu_srl:    res = a >> shamt;
            alu_sra:    res = word_t'($signed(a) >>> shamt); // Sign fill
            alu_or:     res = a | b;
            alu_and:    res = a & b;
            alu_pass_b: res = b;                         // LUI
            default:    res = '0;
        endcase
    end

endmodule

// ==== logic/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Integer datapath width
`define XLEN 32

// addi x0, x0, 0
// Also the idle value of the EX/MEM instruction slot
`define NOP 32'h00000013

// Machine-mode tohost CSR
// Written by the test program to signal completion
`define CSR_TOHOST 12'h51e

`endif

// ==== logic/ex_control.sv ====
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_control (
    input  ex_pkg::inst_t    inst,        // Instruction in EX
    input  ex_pkg::inst_t    mem_inst,    // Next older, now in MEM
    input  ex_pkg::inst_t    wb_inst,     // Oldest still in flight
    input  ex_pkg::word_t    fwd_a,       // rs1 after forwarding
    input  ex_pkg::word_t    fwd_b,       // rs2 after forwarding
    input  logic             br_taken,    // Fetch predictor guess
    output ex_pkg::ex_ctrl_t ctrl,
    output logic             redirect_pc, // Fetch must restart
    output logic             flush,       // Kill younger stages
    output logic             br_suc       // Conditional branch guessed right
);
    import ex_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   mem_rd;
    reg_idx_t   wb_rd;
    logic       mem_fwd_ok; // MEM result usable as a source
    logic       wb_fwd_ok;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       br_eq;
    logic       br_lt;
    logic       cond_taken; // Outcome of the funct3 compare
    logic       act_taken;

    // Opcodes with a destination register
    function automatic logic writes_rd(input inst_t i);
        return i[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                              OPC_REG, OPC_IMM, OPC_LOAD, OPC_SYSTEM};
    endfunction

    // Youngest producer wins, x0 never forwarded
    function automatic fwd_sel_t pick_fwd(input reg_idx_t rs, input reg_idx_t mrd,
                                          input logic mok, input reg_idx_t wrd,
                                          input logic wok);
        if (rs == '0)
            return fwd_none;
        if (mok && rs == mrd)
            return fwd_mem;
        if (wok && rs == wrd)
            return fwd_wb;
        return fwd_none;
    endfunction

    // funct3 plus the bit 30 modifier
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign mem_rd = mem_inst[11:7];
    assign wb_rd  = wb_inst[11:7];

    // Load data only exists after MEM, so a load in MEM is not a source
    assign mem_fwd_ok = writes_rd(mem_inst) && (mem_inst[6:0] != OPC_LOAD);
    assign wb_fwd_ok  = writes_rd(wb_inst);

    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);

    always_comb begin
        ctrl.fwda    = pick_fwd(rs1, mem_rd, mem_fwd_ok, wb_rd, wb_fwd_ok);
        ctrl.fwdb    = pick_fwd(rs2, mem_rd, mem_fwd_ok, wb_rd, wb_fwd_ok);
        ctrl.asel    = a_reg;
        ctrl.bsel    = b_reg;
        ctrl.csr_src = csr_rd1;
        ctrl.csr_en  = 1'b0;
        ctrl.alu_op  = alu_add;
        ctrl.brun    = 1'b0;
        case (opcode)
            OPC_LUI: begin
                ctrl.bsel   = b_imm;
                ctrl.alu_op = alu_pass_b; // Upper immediate straight through
            end
            OPC_AUIPC, OPC_JAL: begin
                ctrl.asel = a_pc;         // pc + imm
                ctrl.bsel = b_imm;
            end
            OPC_JALR, OPC_LOAD, OPC_STORE: ctrl.bsel = b_imm; // rs1 + imm
            OPC_BRANCH: begin
                ctrl.asel = a_pc;         // Target pc + imm
                ctrl.bsel = b_imm;
                ctrl.brun = funct3[1];    // BLTU and BGEU
            end
            OPC_IMM: begin
                ctrl.bsel   = b_imm;
                // Bit 30 only marks SRAI here, it is sign bits for ADDI
                ctrl.alu_op = arith_op(funct3, inst[30] && funct3 == 3'b101);
            end
            OPC_REG: ctrl.alu_op = arith_op(funct3, inst[30]);
            OPC_SYSTEM: begin
                // CSRRW and CSRRWI to tohost
                ctrl.csr_en  = (funct3[1:0] == 2'b01) && (inst[31:20] == `CSR_TOHOST);
                ctrl.csr_src = funct3[2] ? csr_imm : csr_rd1;
            end
            default: ;
        endcase
    end

    // Branch comparator on forwarded operands
    assign br_eq = (fwd_a == fwd_b);
    assign br_lt = ctrl.brun ? (fwd_a < fwd_b) : ($signed(fwd_a) < $signed(fwd_b));

    always_comb begin
        case (funct3)
            3'b000:          cond_taken = br_eq;  // BEQ
            3'b001:          cond_taken = !br_eq; // BNE
            3'b100, 3'b110:  cond_taken = br_lt;  // BLT, BLTU
            3'b101, 3'b111:  cond_taken = !br_lt; // BGE, BGEU
            default:         cond_taken = 1'b0;
        endcase
    end

    assign act_taken = is_jal | is_jalr | (is_branch & cond_taken);

    // JALR target is never predicted
    assign redirect_pc = is_jalr | ((is_branch | is_jal) & (act_taken != br_taken));
    assign flush       = redirect_pc;
    assign br_suc      = is_branch & (cond_taken == br_taken);

endmodule

// ==== logic/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0] word_t;    // Integer data word
    typedef logic [31:0]      inst_t;    // Raw RV32 instruction
    typedef logic [4:0]       reg_idx_t; // Architectural register number

    // Operand source after forwarding
    typedef enum logic [1:0] {
        fwd_none, // Register file value
        fwd_mem,  // ALU result sitting in EX/MEM
        fwd_wb    // Writeback data
    } fwd_sel_t;

    typedef enum logic {a_reg, a_pc} a_sel_t;   // ALU A source
    typedef enum logic {b_reg, b_imm} b_sel_t;  // ALU B source

    // tohost write data
    typedef enum logic {
        csr_imm, // Zero-extended rs1 field, CSRRWI
        csr_rd1  // Forwarded rs1, CSRRW
    } csr_src_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // LUI
    } alu_op_t;

    // EX/MEM pipeline register contents
    typedef struct packed {
        word_t pc;
        word_t alu;    // Result or branch target
        word_t rd2;    // Store data after forwarding
        inst_t inst;
        logic  br_suc; // Predictor was right
    } ex_mem_t;

    // Select bundle from EX control
    typedef struct packed {
        fwd_sel_t fwda;
        fwd_sel_t fwdb;
        a_sel_t   asel;
        b_sel_t   bsel;
        csr_src_t csr_src;
        logic     csr_en;  // Load tohost this cycle
        alu_op_t  alu_op;
        logic     brun;    // Unsigned branch compare
    } ex_ctrl_t;

endpackage

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::word_t   ex_pc,
    input  ex_pkg::word_t   ex_rd1,      // Register file rs1
    input  ex_pkg::word_t   ex_rd2,      // Register file rs2
    input  ex_pkg::word_t   ex_imm,      // Decoded immediate
    input  ex_pkg::inst_t   ex_inst,
    input  logic            ex_br_taken, // Predictor taken flag
    input  ex_pkg::word_t   wb_wdata,    // Writeback result
    input  ex_pkg::inst_t   wb_inst,     // Writeback instruction
    output ex_pkg::word_t   ex_alu,      // Result or branch target
    output logic            ex_redirect_pc,
    output logic            ex_flush,
    output ex_pkg::ex_mem_t mem,         // EX/MEM register
    output ex_pkg::word_t   tohost
);
    import ex_pkg::*;

    ex_ctrl_t ctrl;
    word_t    fwda_out;  // rs1 after forwarding
    word_t    fwdb_out;  // rs2 after forwarding
    word_t    op_a;
    word_t    op_b;
    word_t    csr_wdata;
    logic     br_suc;

    // Shared by both operand paths
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign fwda_out = fwd_mux(ctrl.fwda, ex_rd1, mem.alu, wb_wdata);
    assign fwdb_out = fwd_mux(ctrl.fwdb, ex_rd2, mem.alu, wb_wdata);

    always_comb begin
        case (ctrl.asel)
            a_pc:    op_a = ex_pc;    // AUIPC, JAL, branches
            default: op_a = fwda_out;
        endcase
        case (ctrl.bsel)
            b_imm:   op_b = ex_imm;
            default: op_b = fwdb_out;
        endcase
        case (ctrl.csr_src)
            csr_imm: csr_wdata = word_t'(ex_inst[19:15]); // uimm field
            default: csr_wdata = fwda_out;
        endcase
    end

    ex_control control_i (
        .inst        (ex_inst),
        .mem_inst    (mem.inst),
        .wb_inst     (wb_inst),
        .fwd_a       (fwda_out),
        .fwd_b       (fwdb_out),
        .br_taken    (ex_br_taken),
        .ctrl        (ctrl),
        .redirect_pc (ex_redirect_pc),
        .flush       (ex_flush),
        .br_suc      (br_suc)
    );

    alu alu_i (
        .a   (op_a),
        .b   (op_b),
        .op  (ctrl.alu_op),
        .res (ex_alu)
    );

    // tohost CSR
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tohost <= '0;
        end else if (ctrl.csr_en) begin
            tohost <= csr_wdata;
        end
    end

    // EX/MEM register, loads every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.pc     <= '0;
            mem.alu    <= '0;
            mem.rd2    <= '0;
            mem.inst   <= `NOP;   // Bubble
            mem.br_suc <= 1'b0;
        end else begin
            mem.pc     <= ex_pc;
            mem.alu    <= ex_alu;
            mem.rd2    <= fwdb_out; // Store data
            mem.inst   <= ex_inst;
            mem.br_suc <= br_suc;
        end
    end

    // Redirect only from BRANCH, JAL or JALR opcodes
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_redirect_pc |-> ex_inst[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111});

    // Decode always hands the ALU a defined operation
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(ctrl.alu_op));

    // A reset cycle leaves a bubble in MEM that is never a forwarding source
    assert property (@(posedge clk) !rst_n |=> mem.inst == `NOP
        && ctrl.fwda != fwd_mem && ctrl.fwdb != fwd_mem);

endmodule

// ==== tb.f ====
+incdir+logic
logic/ex_pkg.sv
logic/alu.sv
logic/ex_control.sv
logic/ex_stage.sv
tests/tb_clock.sv
tests/tb_ex_stage.sv

// ==== tests/ex_testdata.txt ====
# pc rd1 rd2 imm br_taken inst wb_wdata wb_inst | exp: ex_alu redirect flush
# mem_alu mem_rd2 mem_br_suc tohost (all hex, one instruction per line)
00000000 00000005 00000007 00000000 0 002081b3 00000000 00000013 0000000c 0 0 0000000c 00000007 0 00000000
00000000 0000000a 00000003 00000000 0 40628233 00000000 00000013 00000007 0 0 00000007 00000003 0 00000000
00000000 00000003 00000004 00000000 0 009413b3 00000000 00000013 00000030 0 0 00000030 00000004 0 00000000
00000000 ffffffff 00000001 00000000 0 00c5a533 00000000 00000013 00000001 0 0 00000001 00000001 0 00000000
00000000 ffffffff 00000001 00000000 0 00f736b3 00000000 00000013 00000000 0 0 00000000 00000001 0 00000000
00000000 f0f0f0f0 ff00ff00 00000000 0 0128c833 00000000 00000013 0ff00ff0 0 0 0ff00ff0 ff00ff00 0 00000000
00000000 80000000 00000004 00000000 0 415a59b3 00000000 00000013 f8000000 0 0 f8000000 00000004 0 00000000
00000000 80000000 00000004 00000000 0 015a5b33 00000000 00000013 08000000 0 0 08000000 00000004 0 00000000
00000000 000000f0 00000f00 00000000 0 0020ebb3 00000000 00000013 00000ff0 0 0 00000ff0 00000f00 0 00000000
00000000 00000ff0 000000f0 00000000 0 0020fc33 00000000 00000013 000000f0 0 0 000000f0 000000f0 0 00000000
00000000 00000010 00000000 ffffffff 0 fff08c93 00000000 00000013 0000000f 0 0 0000000f 00000000 0 00000000
00000000 fffffff0 00000000 00000403 0 4030dd13 00000000 00000013 fffffffe 0 0 fffffffe 00000000 0 00000000
00000000 00000000 00000000 12345000 0 12345db7 00000000 00000013 12345000 0 0 12345000 00000000 0 00000000
00001000 00000000 00000000 00001000 0 00001e17 00000000 00000013 00002000 0 0 00002000 00000000 0 00000000
00000000 00000100 00000023 00000000 0 002082b3 00000000 00000013 00000123 0 0 00000123 00000023 0 00000000
00000000 00000000 00000000 00000000 0 00528333 00000000 00000013 00000246 0 0 00000246 00000123 0 00000000
00000000 00000000 00000005 00000000 0 00a483b3 00000040 00000493 00000045 0 0 00000045 00000005 0 00000000
00000000 00000000 00000077 00000000 0 00038433 00000999 00000393 000000bc 0 0 000000bc 00000077 0 00000000
00000000 00000011 00000000 00000005 0 00500013 00000000 00000013 00000016 0 0 00000016 00000000 0 00000000
00000000 00000001 00000002 00000000 0 00000533 00000000 00000013 00000003 0 0 00000003 00000002 0 00000000
00000000 00000200 00000000 00000000 0 0000a583 00000000 00000013 00000200 0 0 00000200 00000000 0 00000000
00000000 00000030 00000004 00000000 0 00158633 00000000 00000013 00000034 0 0 00000034 00000004 0 00000000
00000100 00000005 00000005 00000010 1 00208863 00000000 00000013 00000110 0 0 00000110 00000005 1 00000000
00000100 00000005 00000005 00000010 0 00208863 00000000 00000013 00000110 1 1 00000110 00000005 0 00000000
00000100 00000005 00000006 00000010 0 00209863 00000000 00000013 00000110 1 1 00000110 00000006 0 00000000
00000100 00000005 00000005 00000010 0 00209863 00000000 00000013 00000110 0 0 00000110 00000005 1 00000000
00000100 ffffffff 00000001 00000010 1 0020c863 00000000 00000013 00000110 0 0 00000110 00000001 1 00000000
00000100 ffffffff 00000001 00000010 0 0020c863 00000000 00000013 00000110 1 1 00000110 00000001 0 00000000
00000100 ffffffff 00000001 00000010 1 0020d863 00000000 00000013 00000110 1 1 00000110 00000001 0 00000000
00000100 00000003 00000003 00000010 1 0020d863 00000000 00000013 00000110 0 0 00000110 00000003 1 00000000
00000100 ffffffff 00000001 00000010 0 0020e863 00000000 00000013 00000110 0 0 00000110 00000001 1 00000000
00000100 00000001 ffffffff 00000010 0 0020e863 00000000 00000013 00000110 1 1 00000110 ffffffff 0 00000000
00000100 ffffffff 00000001 00000010 1 0020f863 00000000 00000013 00000110 0 0 00000110 00000001 1 00000000
00000100 00000001 ffffffff 00000010 1 0020f863 00000000 00000013 00000110 1 1 00000110 ffffffff 0 00000000
00000200 00000000 00000000 00000020 1 020000ef 00000000 00000013 00000220 0 0 00000220 00000000 0 00000000
00000200 00000000 00000000 00000020 0 020000ef 00000000 00000013 00000220 1 1 00000220 00000000 0 00000000
00000300 00001000 00000000 00000008 1 00828067 00000000 00000013 00001008 1 1 00001008 00000000 0 00000000
00000300 00001000 00000000 00000008 0 00828067 00000000 00000013 00001008 1 1 00001008 00000000 0 00000000
00000000 0000cafe 00000000 00000000 0 51e09073 00000000 00000013 0000cafe 0 0 0000cafe 00000000 0 0000cafe
00000000 00000000 00000000 00000000 0 51e3d073 00000000 00000013 00000000 0 0 00000000 00000000 0 00000007
00000000 00000055 00000000 00000000 0 30009073 00000000 00000013 00000055 0 0 00000055 00000000 0 00000007
00000000 00000000 00000000 0000005a 0 05a00713 00000000 00000013 0000005a 0 0 0000005a 00000000 0 00000007
00000000 00001000 00000000 00000004 0 00e0a223 00000000 00000013 00001004 0 0 00001004 0000005a 0 00000007
00000000 00001000 00000000 00000004 0 00f0a223 0000beef 00000793 00001004 0 0 00001004 0000beef 0 00000007

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_NS = 2 // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0; // First rising edge at HALF_NS
    end

    always #(HALF_NS) clk = ~clk;

endmodule

// ==== tests/tb_ex_stage.sv ====
`timescale 1ns/1ns
`include "ex_config.svh"

module tb_ex_stage;
    import ex_pkg::*;

    localparam int MAX_ROWS = 256;
    localparam int N_COLS   = 15;
    localparam int CLK_NS   = 4;

    logic    clk;
    logic    rst_n;
    word_t   ex_pc;
    word_t   ex_rd1;
    word_t   ex_rd2;
    word_t   ex_imm;
    inst_t   ex_inst;
    logic    ex_br_taken;
    word_t   wb_wdata;
    inst_t   wb_inst;
    word_t   ex_alu;
    logic    ex_redirect_pc;
    logic    ex_flush;
    ex_mem_t mem;
    word_t   tohost;

    logic [31:0] rows [0:MAX_ROWS-1][0:N_COLS-1]; // One entry per data line
    int          n_rows;
    logic        loaded; // Watchdog starts once the length is known

    tb_clock clock_i (.clk(clk));

    ex_stage dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_pc          (ex_pc),
        .ex_rd1         (ex_rd1),
        .ex_rd2         (ex_rd2),
        .ex_imm         (ex_imm),
        .ex_inst        (ex_inst),
        .ex_br_taken    (ex_br_taken),
        .wb_wdata       (wb_wdata),
        .wb_inst        (wb_inst),
        .ex_alu         (ex_alu),
        .ex_redirect_pc (ex_redirect_pc),
        .ex_flush       (ex_flush),
        .mem            (mem),
        .tohost         (tohost)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Lines starting with # are column notes
    task automatic load_rows();
        int          fd;
        int          got;
        string       line;
        logic [31:0] v [0:N_COLS-1];
        fd = $fopen("tests/ex_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tests/ex_testdata.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "no test data");
        end
        n_rows = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                          v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (got != N_COLS) begin
                $display("Malformed test data line %0d: %s", n_rows + 1, line);
                $display("Simulation finished: FAIL");
                $fatal(1, "bad test data");
            end
            for (int c = 0; c < N_COLS; c++)
                rows[n_rows][c] = v[c];
            n_rows++;
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input int r);
        ex_pc       = rows[r][0];
        ex_rd1      = rows[r][1];
        ex_rd2      = rows[r][2];
        ex_imm      = rows[r][3];
        ex_br_taken = rows[r][4][0];
        ex_inst     = rows[r][5];
        wb_wdata    = rows[r][6];
        wb_inst     = rows[r][7];
    endtask

    // Same cycle, before the next edge
    task automatic check_comb(input int r);
        check("ex_alu", ex_alu, rows[r][8]);
        check("ex_redirect_pc", 32'(ex_redirect_pc), rows[r][9]);
        check("ex_flush", 32'(ex_flush), rows[r][10]);
    endtask

    // One edge after the row was driven
    task automatic check_reg(input int r);
        check("mem.inst", mem.inst, rows[r][5]);
        check("mem.pc", mem.pc, rows[r][0]);
        check("mem.alu", mem.alu, rows[r][11]);
        check("mem.rd2", mem.rd2, rows[r][12]);
        check("mem.br_suc", 32'(mem.br_suc), rows[r][13]);
        check("tohost", tohost, rows[r][14]);
    endtask

    initial begin
        loaded      = 1'b0;
        rst_n       = 1'b0;
        ex_pc       = '0;
        ex_rd1      = '0;
        ex_rd2      = '0;
        ex_imm      = '0;
        ex_inst     = 32'h00208863; // beq x1, x2 taken and guessed right
        ex_br_taken = 1'b1;
        wb_wdata    = '0;
        wb_inst     = `NOP;
        load_rows();
        loaded = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check("mem.inst in reset", mem.inst, `NOP);
            check("tohost in reset", tohost, '0);
            check("mem.br_suc in reset", 32'(mem.br_suc), '0);
        end
        rst_n       = 1'b1;
        ex_inst     = `NOP; // Bubble until the first data line
        ex_br_taken = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #1;
            if (r > 0)
                check_reg(r - 1); // Previous row just got registered
            drive_row(r);
            #2;
            check_comb(r);
        end
        @(posedge clk);
        #1;
        check_reg(n_rows - 1);
        $display("Simulation finished: PASS");
        $finish;
    end

    // Rows plus reset and slack
    initial begin
        wait (loaded);
        #((n_rows + 10) * CLK_NS);
        $display("Timeout: the test did not finish within %0d ns", (n_rows + 10) * CLK_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog");
    end

endmodule
